//--- rtl/mips_cfg.svh
// Datapath width, register address width and register count defines
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Instruction and data word width
`define INST_SZ 32

// Register address width, matches the rs/rt/rd fields
`define REG_SZ 5

// Number of general purpose registers
`define NUM_REGS 32

`endif

//--- rtl/mips_pkg.sv
// Opcode and ALU operation class types for the decode stage
package mips_pkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    // ALU operation class handed to execute
    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,      // Address calc and addi
        ALU_AND   = 2'b01,
        ALU_FUNCT = 2'b10,      // Execute looks at funct field
        ALU_OR    = 2'b11
    } alu_op_e;

endpackage

//--- rtl/register_file.sv
// Register file with two read ports, a debug read port and write-through
`timescale 1ns/100ps
`include "mips_cfg.svh"

module register_file (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_reg_write,      // Write enable from WB
    input  logic [`REG_SZ-1:0]    i_write_reg,
    input  logic [`INST_SZ-1:0]   i_write_data,
    input  logic [`REG_SZ-1:0]    i_read_reg_1,     // rs
    input  logic [`REG_SZ-1:0]    i_read_reg_2,     // rt
    input  logic [`REG_SZ-1:0]    i_debug_addr,
    output logic [`INST_SZ-1:0]   o_read_data_1,
    output logic [`INST_SZ-1:0]   o_read_data_2,
    output logic [`INST_SZ-1:0]   o_debug_reg
);

    logic [`INST_SZ-1:0] regs [`NUM_REGS];

    // Read with bypass of a same-cycle write
    function automatic logic [`INST_SZ-1:0] read_port(input logic [`REG_SZ-1:0] addr);
        logic [`INST_SZ-1:0] data;
        if (addr == '0) begin
            data = '0;                                  // r0 is hardwired
        end else if (i_reg_write && (i_write_reg == addr)) begin
            data = i_write_data;                        // Write-through
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_reg_write && (i_write_reg != '0)) begin
            regs[i_write_reg] <= i_write_data;          // r0 writes dropped
        end
    end

    always_comb begin
        o_read_data_1 = read_port(i_read_reg_1);
        o_read_data_2 = read_port(i_read_reg_2);
    end

    // Debug port sees stored contents only
    assign o_debug_reg = (i_debug_addr == '0) ? '0 : regs[i_debug_addr];

endmodule

//--- rtl/main_control.sv
// Main control decoder from opcode to the instruction control word
`timescale 1ns/100ps

module main_control (
    input  mips_pkg::opcode_e  i_opcode,
    output logic               o_reg_write,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output logic               o_mem_to_reg,
    output logic               o_alu_src,       // Immediate as ALU operand B
    output logic               o_reg_dst,       // rd as destination
    output mips_pkg::alu_op_e  o_alu_op,
    output logic               o_branch,
    output logic               o_equal,         // beq when set, bne when clear
    output logic               o_jump
);

    import mips_pkg::*;

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        o_reg_write  = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_src    = 1'b0;
        o_reg_dst    = 1'b0;
        o_alu_op     = ALU_ADD;
        o_branch     = 1'b0;
        o_equal      = 1'b0;
        o_jump       = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                o_reg_write = 1'b1;
                o_reg_dst   = 1'b1;
                o_alu_op    = ALU_FUNCT;
            end
            OP_LW: begin
                o_reg_write  = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_alu_src    = 1'b1;
            end
            OP_SW: begin
                o_mem_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            OP_BEQ: begin
                o_branch = 1'b1;
                o_equal  = 1'b1;
            end
            OP_BNE:  o_branch = 1'b1;
            OP_ADDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            OP_ANDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_AND;
            end
            OP_ORI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_OR;
            end
            OP_J:    o_jump = 1'b1;
            default: ;                                  // Unsupported, stays a no-op
        endcase
    end

endmodule

//--- rtl/branch_unit.sv
// Branch operand forwarding, equality compare, decision and target adder
`timescale 1ns/100ps
`include "mips_cfg.svh"

module branch_unit (
    input  logic [`INST_SZ-1:0]  i_read_data_1,
    input  logic [`INST_SZ-1:0]  i_read_data_2,
    input  logic [`INST_SZ-1:0]  i_alu_result_m,     // From MEM stage
    input  logic                 i_forward_eq_a,
    input  logic                 i_forward_eq_b,
    input  logic                 i_branch,
    input  logic                 i_equal,
    input  logic [`INST_SZ-1:0]  i_ext_imm,
    input  logic [`INST_SZ-1:0]  i_npc,
    output logic                 o_pc_src,
    output logic [`INST_SZ-1:0]  o_branch_addr
);

    logic [`INST_SZ-1:0] cmp_a;
    logic [`INST_SZ-1:0] cmp_b;
    logic                operands_eq;

    // Forwarding muxes ahead of the comparator
    assign cmp_a = i_forward_eq_a ? i_alu_result_m : i_read_data_1;
    assign cmp_b = i_forward_eq_b ? i_alu_result_m : i_read_data_2;

    assign operands_eq = (cmp_a == cmp_b);

    // Taken when compare result agrees with beq/bne sense
    assign o_pc_src = i_branch & ~(operands_eq ^ i_equal);

    // Word offset relative to npc
    assign o_branch_addr = i_npc + (i_ext_imm << 2);

endmodule

//--- rtl/decode_stage.sv
// Decode block with register file, control, branch unit, fields and jump target
`timescale 1ns/100ps
`include "mips_cfg.svh"

module decode_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic [`INST_SZ-1:0]  i_instruction,
    input  logic [`INST_SZ-1:0]  i_npc,
    input  logic                 i_forward_eq_a,
    input  logic                 i_forward_eq_b,
    input  logic [`INST_SZ-1:0]  i_alu_result_m,
    input  logic                 i_reg_write,        // WB port
    input  logic [`REG_SZ-1:0]   i_write_reg,
    input  logic [`INST_SZ-1:0]  i_write_data,
    input  logic [`REG_SZ-1:0]   i_debug_addr,
    output logic [`INST_SZ-1:0]  o_debug_reg,
    output logic [`INST_SZ-1:0]  o_read_data_1,
    output logic [`INST_SZ-1:0]  o_read_data_2,
    output logic [`INST_SZ-1:0]  o_ext_imm,
    output logic [`REG_SZ-1:0]   o_rs,
    output logic [`REG_SZ-1:0]   o_rt,
    output logic [`REG_SZ-1:0]   o_rd,
    output logic                 o_reg_write,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output logic                 o_mem_to_reg,
    output logic                 o_alu_src,
    output logic                 o_reg_dst,
    output mips_pkg::alu_op_e    o_alu_op,
    output logic                 o_pc_src,
    output logic [`INST_SZ-1:0]  o_branch_addr,
    output logic                 o_jump,
    output logic [`INST_SZ-1:0]  o_jump_addr
);

    import mips_pkg::*;

    opcode_e opcode;
    logic    branch;
    logic    equal;

    assign opcode = opcode_e'(i_instruction[31:26]);

    // Register fields
    assign o_rs = i_instruction[25:21];
    assign o_rt = i_instruction[20:16];
    assign o_rd = i_instruction[15:11];

    assign o_ext_imm = {{(`INST_SZ-16){i_instruction[15]}}, i_instruction[15:0]};

    // Region bits of npc, then the word index
    assign o_jump_addr = {i_npc[`INST_SZ-1 -: 4], i_instruction[25:0], 2'b00};

    register_file register_file_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_reg_write   (i_reg_write),
        .i_write_reg   (i_write_reg),
        .i_write_data  (i_write_data),
        .i_read_reg_1  (o_rs),
        .i_read_reg_2  (o_rt),
        .i_debug_addr  (i_debug_addr),
        .o_read_data_1 (o_read_data_1),
        .o_read_data_2 (o_read_data_2),
        .o_debug_reg   (o_debug_reg)
    );

    main_control main_control_i (
        .i_opcode     (opcode),
        .o_reg_write  (o_reg_write),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_mem_to_reg (o_mem_to_reg),
        .o_alu_src    (o_alu_src),
        .o_reg_dst    (o_reg_dst),
        .o_alu_op     (o_alu_op),
        .o_branch     (branch),
        .o_equal      (equal),
        .o_jump       (o_jump)
    );

    branch_unit branch_unit_i (
        .i_read_data_1  (o_read_data_1),
        .i_read_data_2  (o_read_data_2),
        .i_alu_result_m (i_alu_result_m),
        .i_forward_eq_a (i_forward_eq_a),
        .i_forward_eq_b (i_forward_eq_b),
        .i_branch       (branch),
        .i_equal        (equal),
        .i_ext_imm      (o_ext_imm),
        .i_npc          (i_npc),
        .o_pc_src       (o_pc_src),
        .o_branch_addr  (o_branch_addr)
    );

endmodule

//--- rtl/id_ex_register.sv
// ID/EX pipeline register with stall hold and flush bubble
`timescale 1ns/100ps
`include "mips_cfg.svh"

module id_ex_register (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_stall,           // Wins over flush
    input  logic                 i_flush,
    input  logic                 i_reg_write,
    input  logic                 i_mem_read,
    input  logic                 i_mem_write,
    input  logic                 i_mem_to_reg,
    input  logic                 i_alu_src,
    input  logic                 i_reg_dst,
    input  mips_pkg::alu_op_e    i_alu_op,
    input  logic [`INST_SZ-1:0]  i_read_data_1,
    input  logic [`INST_SZ-1:0]  i_read_data_2,
    input  logic [`INST_SZ-1:0]  i_ext_imm,
    input  logic [`REG_SZ-1:0]   i_rs,
    input  logic [`REG_SZ-1:0]   i_rt,
    input  logic [`REG_SZ-1:0]   i_rd,
    output logic                 o_reg_write,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output logic                 o_mem_to_reg,
    output logic                 o_alu_src,
    output logic                 o_reg_dst,
    output mips_pkg::alu_op_e    o_alu_op,
    output logic [`INST_SZ-1:0]  o_read_data_1,
    output logic [`INST_SZ-1:0]  o_read_data_2,
    output logic [`INST_SZ-1:0]  o_ext_imm,
    output logic [`REG_SZ-1:0]   o_rs,
    output logic [`REG_SZ-1:0]   o_rt,
    output logic [`REG_SZ-1:0]   o_rd
);

    import mips_pkg::*;

    // Control word
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || (i_flush && !i_stall)) begin
            o_reg_write  <= 1'b0;                       // Bubble
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_alu_src    <= 1'b0;
            o_reg_dst    <= 1'b0;
            o_alu_op     <= ALU_ADD;
        end else if (!i_stall) begin
            o_reg_write  <= i_reg_write;
            o_mem_read   <= i_mem_read;
            o_mem_write  <= i_mem_write;
            o_mem_to_reg <= i_mem_to_reg;
            o_alu_src    <= i_alu_src;
            o_reg_dst    <= i_reg_dst;
            o_alu_op     <= i_alu_op;
        end
    end

    // Operands and fields, contents under a bubble are unused downstream
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_read_data_1 <= '0;
            o_read_data_2 <= '0;
            o_ext_imm     <= '0;
            o_rs          <= '0;
            o_rt          <= '0;
            o_rd          <= '0;
        end else if (!i_stall) begin
            o_read_data_1 <= i_read_data_1;
            o_read_data_2 <= i_read_data_2;
            o_ext_imm     <= i_ext_imm;
            o_rs          <= i_rs;
            o_rt          <= i_rt;
            o_rd          <= i_rd;
        end
    end

endmodule

//--- rtl/decode_top.sv
// Decode stage top with the ID/EX register
`timescale 1ns/100ps
`include "mips_cfg.svh"

module decode_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic [`INST_SZ-1:0]  i_instruction,
    input  logic [`INST_SZ-1:0]  i_npc,
    input  logic                 i_forward_eq_a,
    input  logic                 i_forward_eq_b,
    input  logic [`INST_SZ-1:0]  i_alu_result_m,
    input  logic                 i_reg_write,
    input  logic [`REG_SZ-1:0]   i_write_reg,
    input  logic [`INST_SZ-1:0]  i_write_data,
    input  logic [`REG_SZ-1:0]   i_debug_addr,
    input  logic                 i_stall,
    input  logic                 i_flush,
    output logic [`INST_SZ-1:0]  o_debug_reg,
    output logic                 o_pc_src,
    output logic [`INST_SZ-1:0]  o_branch_addr,
    output logic                 o_jump,
    output logic [`INST_SZ-1:0]  o_jump_addr,
    output logic                 o_reg_write_ex,
    output logic                 o_mem_read_ex,
    output logic                 o_mem_write_ex,
    output logic                 o_mem_to_reg_ex,
    output logic                 o_alu_src_ex,
    output logic                 o_reg_dst_ex,
    output mips_pkg::alu_op_e    o_alu_op_ex,
    output logic [`INST_SZ-1:0]  o_read_data_1_ex,
    output logic [`INST_SZ-1:0]  o_read_data_2_ex,
    output logic [`INST_SZ-1:0]  o_ext_imm_ex,
    output logic [`REG_SZ-1:0]   o_rs_ex,
    output logic [`REG_SZ-1:0]   o_rt_ex,
    output logic [`REG_SZ-1:0]   o_rd_ex
);

    import mips_pkg::*;

    // Decode outputs feeding ID/EX
    logic                reg_write_d;
    logic                mem_read_d;
    logic                mem_write_d;
    logic                mem_to_reg_d;
    logic                alu_src_d;
    logic                reg_dst_d;
    alu_op_e             alu_op_d;
    logic [`INST_SZ-1:0] read_data_1_d;
    logic [`INST_SZ-1:0] read_data_2_d;
    logic [`INST_SZ-1:0] ext_imm_d;
    logic [`REG_SZ-1:0]  rs_d;
    logic [`REG_SZ-1:0]  rt_d;
    logic [`REG_SZ-1:0]  rd_d;

    decode_stage decode_stage_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instruction  (i_instruction),
        .i_npc          (i_npc),
        .i_forward_eq_a (i_forward_eq_a),
        .i_forward_eq_b (i_forward_eq_b),
        .i_alu_result_m (i_alu_result_m),
        .i_reg_write    (i_reg_write),
        .i_write_reg    (i_write_reg),
        .i_write_data   (i_write_data),
        .i_debug_addr   (i_debug_addr),
        .o_debug_reg    (o_debug_reg),
        .o_read_data_1  (read_data_1_d),
        .o_read_data_2  (read_data_2_d),
        .o_ext_imm      (ext_imm_d),
        .o_rs           (rs_d),
        .o_rt           (rt_d),
        .o_rd           (rd_d),
        .o_reg_write    (reg_write_d),
        .o_mem_read     (mem_read_d),
        .o_mem_write    (mem_write_d),
        .o_mem_to_reg   (mem_to_reg_d),
        .o_alu_src      (alu_src_d),
        .o_reg_dst      (reg_dst_d),
        .o_alu_op       (alu_op_d),
        .o_pc_src       (o_pc_src),
        .o_branch_addr  (o_branch_addr),
        .o_jump         (o_jump),
        .o_jump_addr    (o_jump_addr)
    );

    id_ex_register id_ex_register_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_reg_write   (reg_write_d),
        .i_mem_read    (mem_read_d),
        .i_mem_write   (mem_write_d),
        .i_mem_to_reg  (mem_to_reg_d),
        .i_alu_src     (alu_src_d),
        .i_reg_dst     (reg_dst_d),
        .i_alu_op      (alu_op_d),
        .i_read_data_1 (read_data_1_d),
        .i_read_data_2 (read_data_2_d),
        .i_ext_imm     (ext_imm_d),
        .i_rs          (rs_d),
        .i_rt          (rt_d),
        .i_rd          (rd_d),
        .o_reg_write   (o_reg_write_ex),
        .o_mem_read    (o_mem_read_ex),
        .o_mem_write   (o_mem_write_ex),
        .o_mem_to_reg  (o_mem_to_reg_ex),
        .o_alu_src     (o_alu_src_ex),
        .o_reg_dst     (o_reg_dst_ex),
        .o_alu_op      (o_alu_op_ex),
        .o_read_data_1 (o_read_data_1_ex),
        .o_read_data_2 (o_read_data_2_ex),
        .o_ext_imm     (o_ext_imm_ex),
        .o_rs          (o_rs_ex),
        .o_rt          (o_rt_ex),
        .o_rd          (o_rd_ex)
    );

endmodule

//--- verification/decode_sva.sv
// ID/EX bubble, stall hold and r0 read assertions, bound into id_ex_register
`timescale 1ns/100ps
`include "mips_cfg.svh"

module decode_sva (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input logic                 i_stall,
    input logic                 i_flush,
    input logic [`REG_SZ-1:0]   i_rs,           // Straight from the register file fields
    input logic [`REG_SZ-1:0]   i_rt,
    input logic [`INST_SZ-1:0]  i_read_data_1,  // Register file read ports
    input logic [`INST_SZ-1:0]  i_read_data_2,
    input logic                 o_reg_write,
    input logic                 o_mem_read,
    input logic                 o_mem_write,
    input logic                 o_mem_to_reg,
    input logic                 o_alu_src,
    input logic                 o_reg_dst,
    input mips_pkg::alu_op_e    o_alu_op,
    input logic [`INST_SZ-1:0]  o_read_data_1,
    input logic [`INST_SZ-1:0]  o_read_data_2,
    input logic [`INST_SZ-1:0]  o_ext_imm,
    input logic [`REG_SZ-1:0]   o_rs,
    input logic [`REG_SZ-1:0]   o_rt,
    input logic [`REG_SZ-1:0]   o_rd
);

    import mips_pkg::*;

    int unsigned fail_count = 0;                // Read by the testbench

    logic [5:0] ctrl_bits;

    assign ctrl_bits = {o_reg_write, o_mem_read, o_mem_write, o_mem_to_reg, o_alu_src, o_reg_dst};

    // Reset and flush both leave a bubble
    a_bubble: assert property (@(posedge i_clk)
        (!i_rst_n || (i_flush && !i_stall)) |=> ((ctrl_bits == '0) && (o_alu_op == ALU_ADD)))
        else begin
            fail_count++;
            $error("ID/EX control word not cleared after reset or flush");
        end

    a_stall_hold: assert property (@(posedge i_clk)
        (i_rst_n && i_stall) |=> $stable({ctrl_bits, o_alu_op, o_read_data_1, o_read_data_2,
                                          o_ext_imm, o_rs, o_rt, o_rd}))
        else begin
            fail_count++;
            $error("ID/EX outputs changed while stalled");
        end

    // r0 is hardwired on both read ports
    a_r0_zero: assert property (@(posedge i_clk)
        ((i_rs == '0) |-> (i_read_data_1 == '0)) and ((i_rt == '0) |-> (i_read_data_2 == '0)))
        else begin
            fail_count++;
            $error("Register 0 read back a nonzero value");
        end

endmodule

bind id_ex_register decode_sva decode_sva_i (.*);

//--- verification/tb_decode_top.sv
// Testbench for decode_top with reference functions, stimulus, compare process and watchdog
`timescale 1ns/100ps
`include "mips_cfg.svh"

module tb_decode_top;

    import mips_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_RAND     = 40;
    localparam int NUM_JUMP     = 4;
    // Random, write-through, branch, jump, sweep, stall/flush and drain cycles
    localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_RAND + 3 + 18 + NUM_JUMP + 10 + 8 + 2;
    localparam int EX_W         = 8 + 3 * `INST_SZ + 3 * `REG_SZ;
    localparam logic [5:0] SWEEP_OPS [10] = '{OP_RTYPE, OP_LW, OP_SW, OP_BEQ, OP_BNE,
                                              OP_ADDI, OP_ANDI, OP_ORI, OP_J, 6'b111111};

    logic                i_clk = 1'b0;
    logic                i_rst_n;
    logic [`INST_SZ-1:0] i_instruction;
    logic [`INST_SZ-1:0] i_npc;
    logic                i_forward_eq_a;
    logic                i_forward_eq_b;
    logic [`INST_SZ-1:0] i_alu_result_m;
    logic                i_reg_write;
    logic [`REG_SZ-1:0]  i_write_reg;
    logic [`INST_SZ-1:0] i_write_data;
    logic [`REG_SZ-1:0]  i_debug_addr;
    logic                i_stall;
    logic                i_flush;
    logic [`INST_SZ-1:0] o_debug_reg;
    logic                o_pc_src;
    logic [`INST_SZ-1:0] o_branch_addr;
    logic                o_jump;
    logic [`INST_SZ-1:0] o_jump_addr;
    logic                o_reg_write_ex;
    logic                o_mem_read_ex;
    logic                o_mem_write_ex;
    logic                o_mem_to_reg_ex;
    logic                o_alu_src_ex;
    logic                o_reg_dst_ex;
    alu_op_e             o_alu_op_ex;
    logic [`INST_SZ-1:0] o_read_data_1_ex;
    logic [`INST_SZ-1:0] o_read_data_2_ex;
    logic [`INST_SZ-1:0] o_ext_imm_ex;
    logic [`REG_SZ-1:0]  o_rs_ex;
    logic [`REG_SZ-1:0]  o_rt_ex;
    logic [`REG_SZ-1:0]  o_rd_ex;

    logic [`INST_SZ-1:0] shadow [`NUM_REGS];    // Expected register contents
    logic                exp_valid = 1'b0;      // Instruction presented this cycle
    logic                chk_valid = 1'b0;      // Captured into ID/EX at the last edge
    logic [EX_W-1:0]     exp_word;
    logic [EX_W-1:0]     chk_word;
    string               cur_test;
    string               exp_test;
    string               chk_test;

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    decode_top dut_i (.*);

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // {reg_write, mem_read, mem_write, mem_to_reg, alu_src, reg_dst, alu_op}
    function automatic logic [7:0] ctrl_ref(input logic [5:0] op);
        logic [7:0] word;
        case (op)
            OP_RTYPE: word = {6'b100001, ALU_FUNCT};
            OP_LW:    word = {6'b110110, ALU_ADD};
            OP_SW:    word = {6'b001010, ALU_ADD};
            OP_ADDI:  word = {6'b100010, ALU_ADD};
            OP_ANDI:  word = {6'b100010, ALU_AND};
            OP_ORI:   word = {6'b100010, ALU_OR};
            default:  word = {6'b000000, ALU_ADD};  // Branches, j, unlisted
        endcase
        return word;
    endfunction

    function automatic logic [`INST_SZ-1:0] sext_ref(input logic [15:0] imm);
        return {{(`INST_SZ-16){imm[15]}}, imm};
    endfunction

    function automatic logic branch_ref(input logic [5:0] op, input logic [`INST_SZ-1:0] a,
                                        input logic [`INST_SZ-1:0] b);
        return ((op == OP_BEQ) && (a == b)) || ((op == OP_BNE) && (a != b));
    endfunction

    function automatic logic [`INST_SZ-1:0] branch_addr_ref(input logic [`INST_SZ-1:0] npc,
                                                            input logic [15:0] imm);
        return npc + sext_ref(imm) * 4;
    endfunction

    function automatic logic [`INST_SZ-1:0] jump_addr_ref(input logic [`INST_SZ-1:0] npc,
                                                          input logic [`INST_SZ-1:0] instr);
        return {npc[31:28], instr[25:0], 2'b00};
    endfunction

    // Register read as seen by decode, including a same-cycle write
    function automatic logic [`INST_SZ-1:0] read_ref(input logic [`REG_SZ-1:0] addr,
            input logic we, input logic [`REG_SZ-1:0] wreg, input logic [`INST_SZ-1:0] wdata);
        if (addr == '0) begin
            return '0;
        end
        if (we && (wreg == addr)) begin
            return wdata;
        end
        return shadow[addr];
    endfunction

    function automatic logic [7:0] ex_control();
        return {o_reg_write_ex, o_mem_read_ex, o_mem_write_ex, o_mem_to_reg_ex,
                o_alu_src_ex, o_reg_dst_ex, o_alu_op_ex};
    endfunction

    function automatic logic [EX_W-1:0] ex_outputs();
        return {ex_control(), o_read_data_1_ex, o_read_data_2_ex, o_ext_imm_ex,
                o_rs_ex, o_rt_ex, o_rd_ex};
    endfunction

    // One decode cycle, combinational outputs checked at the falling edge
    task automatic drive_cycle(input logic [31:0] instr, input logic [31:0] npc,
                               input logic fwd_a, input logic fwd_b, input logic [31:0] alu_m,
                               input logic we, input logic [4:0] wreg, input logic [31:0] wdata,
                               input logic stall, input logic flush);
        logic [`INST_SZ-1:0] rd1;
        logic [`INST_SZ-1:0] rd2;
        logic [`INST_SZ-1:0] cmp_a;
        logic [`INST_SZ-1:0] cmp_b;
        logic [`INST_SZ-1:0] dbg_exp;
        @(posedge i_clk);
        i_instruction  <= instr;
        i_npc          <= npc;
        i_forward_eq_a <= fwd_a;
        i_forward_eq_b <= fwd_b;
        i_alu_result_m <= alu_m;
        i_reg_write    <= we;
        i_write_reg    <= wreg;
        i_write_data   <= wdata;
        i_debug_addr   <= instr[25:21];
        i_stall        <= stall;
        i_flush        <= flush;
        rd1     = read_ref(instr[25:21], we, wreg, wdata);
        rd2     = read_ref(instr[20:16], we, wreg, wdata);
        cmp_a   = fwd_a ? alu_m : rd1;
        cmp_b   = fwd_b ? alu_m : rd2;
        dbg_exp = shadow[instr[25:21]];         // Debug port has no bypass
        exp_valid <= !stall && !flush;
        exp_test  <= cur_test;
        exp_word  <= {ctrl_ref(instr[31:26]), rd1, rd2, sext_ref(instr[15:0]), instr[25:11]};
        if (we && (wreg != '0)) begin
            shadow[wreg] = wdata;               // Lands at the next edge
        end
        @(negedge i_clk);
        check_value({cur_test, " pc_src"}, branch_ref(instr[31:26], cmp_a, cmp_b), o_pc_src);
        check_value({cur_test, " branch_addr"}, branch_addr_ref(npc, instr[15:0]), o_branch_addr);
        check_value({cur_test, " jump"}, instr[31:26] == OP_J, o_jump);
        check_value({cur_test, " jump_addr"}, jump_addr_ref(npc, instr), o_jump_addr);
        check_value({cur_test, " debug_reg"}, dbg_exp, o_debug_reg);
    endtask

    // ID/EX outputs one cycle after each unstalled, unflushed instruction
    always @(posedge i_clk) begin
        chk_valid <= exp_valid;
        chk_word  <= exp_word;
        chk_test  <= exp_test;
    end

    always @(negedge i_clk) begin
        if (chk_valid) begin
            check_value({chk_test, " id_ex"}, chk_word, ex_outputs());
        end
    end

    always @(negedge i_clk) begin
        if (dut_i.id_ex_register_i.decode_sva_i.fail_count != 0) begin
            $display("A bound assertion on ID/EX or the register file failed");
            $display("Test failures found");
            $fatal(1, "Assertion failure");
        end
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_CYCLES + 20));
        $display("Watchdog expired before the decode tests finished");
        $display("Test failures found");
        $fatal(1, "Timeout");
    end

    initial begin
        int              i;
        logic [`REG_SZ-1:0]  rs;
        logic [`REG_SZ-1:0]  rt;
        logic [`INST_SZ-1:0] wdata;
        logic [`INST_SZ-1:0] alu_m;
        logic [5:0]          op;
        logic [EX_W-1:0]     held;
        void'($urandom(87));
        i_rst_n        = 1'b0;
        i_instruction  = '0;
        i_npc          = '0;
        i_forward_eq_a = 1'b0;
        i_forward_eq_b = 1'b0;
        i_alu_result_m = '0;
        i_reg_write    = 1'b0;
        i_write_reg    = '0;
        i_write_data   = '0;
        i_debug_addr   = '0;
        i_stall        = 1'b0;
        i_flush        = 1'b0;
        cur_test       = "reset";
        for (i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;

        cur_test = "regfile_random";            // Random rs may hit the write target
        for (i = 0; i < NUM_RAND; i++) begin
            rs    = 5'($urandom);
            rt    = 5'($urandom);
            wdata = $urandom;
            drive_cycle({OP_RTYPE, rs, rt, 16'($urandom)}, $urandom, 1'b0, 1'b0, '0,
                        1'b1, 5'($urandom), wdata, 1'b0, 1'b0);
        end

        cur_test = "write_through";
        drive_cycle({OP_RTYPE, 5'd0, 5'd0, 16'h0}, '0, 1'b0, 1'b0, '0,
                    1'b1, 5'd0, $urandom, 1'b0, 1'b0);
        drive_cycle({OP_RTYPE, 5'd7, 5'd0, 16'h3820}, '0, 1'b0, 1'b0, '0,
                    1'b1, 5'd7, $urandom, 1'b0, 1'b0);
        drive_cycle({OP_RTYPE, 5'd7, 5'd7, 16'h0}, '0, 1'b0, 1'b0, '0,
                    1'b0, 5'd0, '0, 1'b0, 1'b0);

        cur_test = "branch";
        wdata = $urandom;
        drive_cycle('0, '0, 1'b0, 1'b0, '0, 1'b1, 5'd3, wdata, 1'b0, 1'b0);
        drive_cycle('0, '0, 1'b0, 1'b0, '0, 1'b1, 5'd4, wdata ^ 32'h1, 1'b0, 1'b0);
        for (i = 0; i < 16; i++) begin
            op    = i[3] ? OP_BNE : OP_BEQ;
            rt    = i[0] ? 5'd3 : 5'd4;         // Bit 0 asks for equal operands
            alu_m = i[0] ? shadow[3] : ~shadow[3];
            drive_cycle({op, 5'd3, rt, 16'($urandom)}, $urandom, i[2], i[1], alu_m,
                        1'b0, '0, '0, 1'b0, 1'b0);
        end

        cur_test = "jump";
        for (i = 0; i < NUM_JUMP; i++) begin
            drive_cycle({OP_J, 26'($urandom)}, $urandom, 1'b0, 1'b0, '0,
                        1'b0, '0, '0, 1'b0, 1'b0);
        end

        cur_test = "opcode_sweep";
        for (i = 0; i < 10; i++) begin
            drive_cycle({SWEEP_OPS[i], 26'($urandom)}, $urandom, 1'b0, 1'b0, '0,
                        1'b0, '0, '0, 1'b0, 1'b0);
        end

        cur_test = "stall_flush";
        drive_cycle({OP_ADDI, 26'($urandom)}, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        drive_cycle({OP_ORI, 26'($urandom)}, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b1, 1'b0);
        held = chk_word;                        // addi still in ID/EX
        drive_cycle({OP_ANDI, 26'($urandom)}, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        check_value("stall_flush hold", held, ex_outputs());
        drive_cycle({OP_LW, 26'($urandom)}, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b1);
        drive_cycle({OP_SW, 26'($urandom)}, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        check_value("stall_flush bubble", {6'b000000, ALU_ADD}, ex_control());
        drive_cycle({OP_BEQ, 26'($urandom)}, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b1, 1'b1);
        held = chk_word;                        // sw still in ID/EX
        drive_cycle('0, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        check_value("stall_flush priority", held, ex_outputs());
        drive_cycle('0, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        repeat (2) @(posedge i_clk);            // Let the compare process drain

        if (dut_i.id_ex_register_i.decode_sva_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Assertion failures were reported during the run");
            $display("Test failures found");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

//--- project.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/register_file.sv
rtl/main_control.sv
rtl/branch_unit.sv
rtl/decode_stage.sv
rtl/id_ex_register.sv
rtl/decode_top.sv
verification/decode_sva.sv
verification/tb_decode_top.sv
